// File: sim.f
+incdir+common
common/sdmac_pkg.sv
hw/bus_decode.sv
hw/reg_execute.sv
hw/read_result.sv
hw/sdmac_regs.sv
tb/sdmac_regs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the register block testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module sdmac_regs_tb -Mdir obj_dir -o sdmac_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sdmac_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

// File: tb/sdmac_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_config.svh"

module sdmac_regs_tb;

    typedef enum int {OP_IDLE, OP_READ, OP_WRITE, OP_XFER, OP_SCSI, OP_FIFO, OP_IRQ} op_t;

    logic        clk = 1'b0;
    logic        _RST;
    logic [7:0]  addr;
    logic        _cs;
    logic        _as;
    logic        _ds;
    logic        r_w;
    logic [31:0] din;
    logic        word_xfer;
    logic        scsi_int;
    logic        fifo_empty;
    logic [31:0] dout;
    logic        dsack;
    logic        st_dma;
    logic        flush;
    logic        sp_dma;
    logic        irq;
    logic [23:0] wtc;

    // Test table with one entry per row in each queue
    string       tname[$];
    op_t         top[$];
    logic [7:0]  taddr[$];
    logic [31:0] tdata[$];
    logic [31:0] texp[$];

    int   errors = 0;
    int   cycles = 0;
    int   limit = 0;
    logic row_bad;
    int   st_cnt;
    int   fl_cnt;
    int   sp_cnt;

    sdmac_regs i_sdmac_regs (
        .clk(clk), ._RST(_RST), .addr(addr), ._cs(_cs), ._as(_as), ._ds(_ds), .r_w(r_w),
        .din(din), .word_xfer(word_xfer), .scsi_int(scsi_int), .fifo_empty(fifo_empty),
        .dout(dout), .dsack(dsack), .st_dma(st_dma), .flush(flush), .sp_dma(sp_dma),
        .irq(irq), .wtc(wtc)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the bus handshake stalled", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Width of each command pulse in cycles
    always @(negedge clk) begin
        if (st_dma) st_cnt++;
        if (flush) fl_cnt++;
        if (sp_dma) sp_cnt++;
    end

    function automatic void add_row(input string n, input op_t op, input logic [7:0] a,
                                    input logic [31:0] d, input logic [31:0] e);
        tname.push_back(n);
        top.push_back(op);
        taddr.push_back(a);
        tdata.push_back(d);
        texp.push_back(e);
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    task automatic pulse_width(input string name, input string sig, input int cnt, input int exp);
        if (cnt != exp) begin
            $display("%s: %s was high for %0d cycles instead of %0d", name, sig, cnt, exp);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    // One CPU cycle started right after a rising edge
    task automatic bus_access(input string name, input logic [7:0] a, input logic rd,
                              input logic [31:0] d, output logic [31:0] rdata);
        int n;
        addr <= a;
        r_w  <= rd;
        din  <= d;
        _cs  <= 1'b0;
        _as  <= 1'b0;
        repeat (2) @(posedge clk);
        _ds <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!dsack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!dsack) begin
            $display("%s: dsack never rose after _DS fell", name);
            errors++;
            row_bad = 1'b1;
        end
        rdata = dout;
        @(posedge clk);
        _ds <= 1'b1;
        _as <= 1'b1;
        _cs <= 1'b1;
        r_w <= 1'b1;
        n = 1;
        @(negedge clk);
        while (dsack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (dsack || n - 1 != 3) begin
            $display("%s: dsack did not fall three edges after _DS rose", name);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] rnd;
        int          rows_bad;
        rows_bad = 0;
        void'($urandom(2));
        rnd = $urandom;
        add_row("reset_idle",  OP_IDLE,  8'h00, 0, 0);
        add_row("rst_wtc",     OP_READ,  `ADDR_WTC, 0, 0);
        add_row("rst_cntr",    OP_READ,  `ADDR_CNTR, 0, 0);
        add_row("rst_istr",    OP_READ,  `ADDR_ISTR, 0, 0);
        add_row("wr_wtc",      OP_WRITE, `ADDR_WTC, rnd, 0);
        add_row("rd_wtc",      OP_READ,  `ADDR_WTC, 0, rnd & 32'h00FF_FFFF);  // 24 bit count
        add_row("wr_cntr",     OP_WRITE, `ADDR_CNTR, 32'hFFFF_FFFF, 0);
        add_row("rd_cntr",     OP_READ,  `ADDR_CNTR, 0, 32'h3F);
        add_row("wr_dawr",     OP_WRITE, `ADDR_DAWR, 32'h3, 0);
        add_row("rd_dawr",     OP_READ,  `ADDR_DAWR, 0, 0);
        add_row("rd_unmapped", OP_READ,  8'h40, 0, 0);
        add_row("wr_st_dma",   OP_WRITE, `ADDR_ST_DMA, 0, 0);
        add_row("istr_active", OP_READ,  `ADDR_ISTR, 0, 32'd1 << `ISTR_DMA_ACT);
        add_row("rd_sp_dma",   OP_READ,  `ADDR_SP_DMA, 0, 0);
        add_row("rd_st_dma",   OP_READ,  `ADDR_ST_DMA, 0, 0);
        add_row("wr_flush",    OP_WRITE, `ADDR_FLUSH, 0, 0);
        add_row("rd_flush",    OP_READ,  `ADDR_FLUSH, 0, 0);
        add_row("wr_sp_dma",   OP_WRITE, `ADDR_SP_DMA, 0, 0);
        add_row("istr_idle",   OP_READ,  `ADDR_ISTR, 0, 0);
        add_row("cntr_noint",  OP_WRITE, `ADDR_CNTR, 0, 0);
        add_row("wr_wtc_n",    OP_WRITE, `ADDR_WTC, 5, 0);
        add_row("start_xfer",  OP_WRITE, `ADDR_ST_DMA, 0, 0);
        add_row("xfer_5",      OP_XFER,  8'h00, 5, 0);
        add_row("rd_wtc_end",  OP_READ,  `ADDR_WTC, 0, 0);
        add_row("istr_end",    OP_READ,  `ADDR_ISTR, 0,
                (32'd1 << `ISTR_INT_F) | (32'd1 << `ISTR_E_INT));
        add_row("irq_masked",  OP_IRQ,   8'h00, 0, 0);
        add_row("cntr_inten",  OP_WRITE, `ADDR_CNTR, 32'd1 << `CNTR_INTEN, 0);
        add_row("irq_on",      OP_IRQ,   8'h00, 0, 1);
        add_row("wr_cint",     OP_WRITE, `ADDR_CINT, 0, 0);
        add_row("istr_clr",    OP_READ,  `ADDR_ISTR, 0, 0);
        add_row("irq_off",     OP_IRQ,   8'h00, 0, 0);
        add_row("scsi_pulse",  OP_SCSI,  8'h00, 0, 0);
        add_row("fifo_set",    OP_FIFO,  8'h00, 1, 0);
        add_row("istr_scsi",   OP_READ,  `ADDR_ISTR, 0, (32'd1 << `ISTR_INT_F) |
                (32'd1 << `ISTR_INTS) | (32'd1 << `ISTR_FE));
        add_row("irq_scsi",    OP_IRQ,   8'h00, 0, 1);
        add_row("rd_cint",     OP_READ,  `ADDR_CINT, 0, 0);
        add_row("irq_clr",     OP_IRQ,   8'h00, 0, 0);
        limit = 60 * tname.size() + 4;

        _RST = 1'b0;
        addr = 8'hFF;
        _cs = 1'b1;
        _as = 1'b1;
        _ds = 1'b1;
        r_w = 1'b1;
        din = '0;
        word_xfer = 1'b0;
        scsi_int = 1'b0;
        fifo_empty = 1'b0;
        repeat (4) @(posedge clk);
        _RST <= 1'b1;

        for (int i = 0; i < tname.size(); i++) begin
            @(posedge clk);
            row_bad = 1'b0;
            st_cnt = 0;
            fl_cnt = 0;
            sp_cnt = 0;
            case (top[i])
                OP_IDLE: begin
                    @(negedge clk);
                    compare(tname[i], texp[i], 32'({dsack, irq, st_dma, flush, sp_dma}));
                    compare(tname[i], texp[i], dout);
                end
                OP_READ, OP_WRITE: begin
                    bus_access(tname[i], taddr[i], top[i] == OP_READ, tdata[i], rdata);
                    if (top[i] == OP_READ) compare(tname[i], texp[i], rdata);
                end
                OP_XFER: begin
                    word_xfer <= 1'b1;  // One word per cycle
                    repeat (tdata[i]) @(posedge clk);
                    word_xfer <= 1'b0;
                    @(negedge clk);
                    compare(tname[i], texp[i], 32'(wtc));
                end
                OP_SCSI: begin
                    scsi_int <= 1'b1;
                    @(posedge clk);
                    scsi_int <= 1'b0;
                end
                OP_FIFO: fifo_empty <= tdata[i][0];
                default: begin
                    @(negedge clk);
                    compare(tname[i], texp[i], 32'(irq));
                end
            endcase
            // Only an access to a command offset may pulse
            pulse_width(tname[i], "st_dma", st_cnt,
                        int'(top[i] inside {OP_READ, OP_WRITE} && taddr[i] == `ADDR_ST_DMA));
            pulse_width(tname[i], "flush", fl_cnt,
                        int'(top[i] inside {OP_READ, OP_WRITE} && taddr[i] == `ADDR_FLUSH));
            pulse_width(tname[i], "sp_dma", sp_cnt,
                        int'(top[i] inside {OP_READ, OP_WRITE} && taddr[i] == `ADDR_SP_DMA));
            if (row_bad) rows_bad++;
            $display("%-12s %s", tname[i], row_bad ? "mismatch" : "ok");
        end

        $display("%0d tests run, %0d with mismatches, %0d errors", tname.size(), rows_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/sdmac_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sdmac_regs
    import sdmac_pkg::*;
(
    input  wire        clk,
    input  wire        _RST,
    input  wire        [7:0] addr,   // Register offset
    input  wire        _cs,
    input  wire        _as,
    input  wire        _ds,
    input  wire        r_w,          // High for read
    input  wire        [31:0] din,
    input  wire        word_xfer,    // One pulse per DMA word
    input  wire        scsi_int,
    input  wire        fifo_empty,
    output bus_data_t  dout,
    output logic       dsack,
    output logic       st_dma,
    output logic       flush,
    output logic       sp_dma,
    output logic       irq,
    output wtc_t       wtc
);

    logic      acc_valid;
    reg_addr_t acc_addr;
    logic      acc_read;
    logic      ds_released;
    dawr_t     dawr;
    cntr_t     cntr;
    istr_t     istr;

    bus_decode i_bus_decode (
        .clk         (clk),
        ._RST        (_RST),
        .addr        (addr),
        ._cs         (_cs),
        ._as         (_as),
        ._ds         (_ds),
        .r_w         (r_w),
        .dsack       (dsack),
        .acc_valid   (acc_valid),
        .acc_addr    (acc_addr),
        .acc_read    (acc_read),
        .ds_released (ds_released)
    );

    reg_execute i_reg_execute (
        .clk        (clk),
        ._RST       (_RST),
        .acc_valid  (acc_valid),
        .acc_addr   (acc_addr),
        .acc_read   (acc_read),
        .din        (din),
        .word_xfer  (word_xfer),
        .scsi_int   (scsi_int),
        .fifo_empty (fifo_empty),
        .dawr       (dawr),
        .wtc        (wtc),
        .cntr       (cntr),
        .istr       (istr),
        .st_dma     (st_dma),
        .flush      (flush),
        .sp_dma     (sp_dma),
        .irq        (irq)
    );

    read_result i_read_result (
        .clk         (clk),
        ._RST        (_RST),
        .acc_valid   (acc_valid),
        .acc_addr    (acc_addr),
        .acc_read    (acc_read),
        .ds_released (ds_released),
        .dawr        (dawr),
        .wtc         (wtc),
        .cntr        (cntr),
        .istr        (istr),
        .dout        (dout),
        .dsack       (dsack)
    );

endmodule

`default_nettype wire

// File: hw/read_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_config.svh"

module read_result
    import sdmac_pkg::*;
(
    input  wire        clk,
    input  wire        _RST,
    input  wire        acc_valid,
    input  wire        [7:0] acc_addr,
    input  wire        acc_read,
    input  wire        ds_released,
    input  wire        [1:0] dawr,
    input  wire        [23:0] wtc,
    input  wire        [5:0] cntr,
    input  wire        [8:0] istr,
    output bus_data_t  dout,
    output logic       dsack
);

    always_ff @(posedge clk) begin
        if (!_RST) begin
            dout  <= '0;
            dsack <= 1'b0;
        end else begin
            // Read data mux that leaves dout alone on writes
            if (acc_valid && acc_read) begin
                case (acc_addr)
                    `ADDR_WTC:  dout <= bus_data_t'(wtc);
                    `ADDR_CNTR: dout <= bus_data_t'(cntr);
                    `ADDR_ISTR: dout <= bus_data_t'(istr);
                    default:    dout <= '0;  // DAWR is write only
                endcase
            end

            // Acknowledge held until the CPU lets go of _DS
            if (acc_valid) begin
                dsack <= 1'b1;
            end else if (ds_released) begin
                dsack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_config.svh"

module reg_execute
    import sdmac_pkg::*;
(
    input  wire        clk,
    input  wire        _RST,
    input  wire        acc_valid,
    input  wire        [7:0] acc_addr,
    input  wire        acc_read,
    input  wire        [31:0] din,
    input  wire        word_xfer,
    input  wire        scsi_int,
    input  wire        fifo_empty,
    output dawr_t      dawr,
    output wtc_t       wtc,
    output cntr_t      cntr,
    output istr_t      istr,
    output logic       st_dma,
    output logic       flush,
    output logic       sp_dma,
    output logic       irq
);

    logic dma_act;
    logic ints;
    logic e_int;

    // Access decode, commands fire on reads as well as writes
    logic wr;
    logic wtc_wr;
    logic start_acc;
    logic stop_acc;
    logic cint_acc;
    logic xfer_end;

    assign wr        = acc_valid && !acc_read;
    assign wtc_wr    = wr && (acc_addr == `ADDR_WTC);
    assign start_acc = acc_valid && (acc_addr == `ADDR_ST_DMA);
    assign stop_acc  = acc_valid && (acc_addr == `ADDR_SP_DMA);
    assign cint_acc  = acc_valid && (acc_addr == `ADDR_CINT);

    // Last word of the transfer, a WTC write in the same cycle takes over
    assign xfer_end = word_xfer && !wtc_wr && (wtc == wtc_t'(1));

    always_ff @(posedge clk) begin
        if (!_RST) begin
            dawr    <= '0;
            wtc     <= '0;
            cntr    <= '0;
            st_dma  <= 1'b0;
            flush   <= 1'b0;
            sp_dma  <= 1'b0;
            dma_act <= 1'b0;
            ints    <= 1'b0;
            e_int   <= 1'b0;
        end else begin
            st_dma <= start_acc;  // One cycle command pulses
            flush  <= acc_valid && (acc_addr == `ADDR_FLUSH);
            sp_dma <= stop_acc;

            if (wr && (acc_addr == `ADDR_DAWR)) dawr <= din[$bits(dawr_t)-1:0];
            if (wr && (acc_addr == `ADDR_CNTR)) cntr <= din[$bits(cntr_t)-1:0];

            if (wtc_wr) begin
                wtc <= din[$bits(wtc_t)-1:0];
            end else if (word_xfer && (wtc != '0)) begin
                wtc <= wtc - wtc_t'(1);  // Stops at zero
            end

            // A new interrupt in the clear cycle stays latched
            ints  <= scsi_int || (ints && !cint_acc);
            e_int <= xfer_end || (e_int && !cint_acc);

            if (start_acc) begin
                dma_act <= 1'b1;
            end else if (stop_acc || xfer_end) begin
                dma_act <= 1'b0;
            end
        end
    end

    always_comb begin
        istr                = '0;
        istr[`ISTR_INT_F]   = ints || e_int;
        istr[`ISTR_INTS]    = ints;
        istr[`ISTR_E_INT]   = e_int;
        istr[`ISTR_DMA_ACT] = dma_act;
        istr[`ISTR_FE]      = fifo_empty;  // Live FIFO state
    end

    assign irq = istr[`ISTR_INT_F] && cntr[`CNTR_INTEN];

endmodule

`default_nettype wire

// File: hw/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode
    import sdmac_pkg::*;
(
    input  wire        clk,
    input  wire        _RST,
    input  wire        [7:0] addr,
    input  wire        _cs,
    input  wire        _as,
    input  wire        _ds,
    input  wire        r_w,
    input  wire        dsack,
    output logic       acc_valid,
    output reg_addr_t  acc_addr,
    output logic       acc_read,
    output logic       ds_released
);

    // Two flop synchronizers for the CPU strobes
    logic cs_s1;
    logic cs_s2;
    logic as_s1;
    logic as_s2;
    logic ds_s1;
    logic ds_s2;

    acc_state_t state;

    always_ff @(posedge clk) begin
        if (!_RST) begin
            cs_s1 <= 1'b1;  // Strobes idle high
            cs_s2 <= 1'b1;
            as_s1 <= 1'b1;
            as_s2 <= 1'b1;
            ds_s1 <= 1'b1;
            ds_s2 <= 1'b1;
        end else begin
            cs_s1 <= _cs;
            cs_s2 <= cs_s1;
            as_s1 <= _as;
            as_s2 <= as_s1;
            ds_s1 <= _ds;
            ds_s2 <= ds_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (!_RST) begin
            state     <= IDLE;
            acc_valid <= 1'b0;
            acc_addr  <= 8'hFF;
            acc_read  <= 1'b1;
        end else begin
            acc_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (!as_s2) begin
                        // Hold off until the previous acknowledge has dropped
                        if (!cs_s2 && !dsack) begin
                            acc_addr <= addr;
                            state    <= ADDR_HELD;
                        end else if (cs_s2) begin
                            acc_addr <= 8'hFF;  // Cycle meant for another device
                        end
                    end
                end
                ADDR_HELD: begin
                    if (as_s2) begin
                        state <= IDLE;  // Address only cycle
                    end else if (!ds_s2) begin
                        acc_valid <= 1'b1;
                        acc_read  <= r_w;  // Stable while _DS is low
                        state     <= DONE;
                    end
                end
                DONE: begin
                    if (as_s2) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ds_released = ds_s2;

endmodule

`default_nettype wire

// File: common/sdmac_pkg.sv
`default_nettype none

package sdmac_pkg;

    // Register offset as seen on the CPU address bus
    typedef logic [7:0] reg_addr_t;

    // CPU data bus word
    typedef logic [31:0] bus_data_t;

    // Word transfer count, counts down once per DMA word
    typedef logic [23:0] wtc_t;

    // Control register
    typedef logic [5:0] cntr_t;

    // Data acknowledge width
    typedef logic [1:0] dawr_t;

    // Interrupt status as read back by the CPU
    typedef logic [8:0] istr_t;

    // CPU access sequencing in bus_decode
    typedef enum logic [1:0] {
        IDLE,       // Waiting for a selected address strobe
        ADDR_HELD,  // Address latched, waiting for the data strobe
        DONE        // Access issued, waiting for the address strobe to rise
    } acc_state_t;

endpackage

`default_nettype wire

// File: common/sdmac_config.svh
`ifndef SDMAC_CONFIG_SVH
`define SDMAC_CONFIG_SVH

// Register offsets on the CPU address bus
`define ADDR_DAWR   8'h00  // Write only
`define ADDR_WTC    8'h04
`define ADDR_CNTR   8'h08
`define ADDR_ST_DMA 8'h10
`define ADDR_FLUSH  8'h14
`define ADDR_CINT   8'h18
`define ADDR_ISTR   8'h1C  // Read only
`define ADDR_SP_DMA 8'h3C

// ISTR bit positions, unlisted bits read 0
`define ISTR_INT_F   8  // Any interrupt pending
`define ISTR_INTS    7  // SCSI interrupt latched
`define ISTR_E_INT   6  // Transfer end latched
`define ISTR_DMA_ACT 5
`define ISTR_FE      0  // FIFO empty

// CNTR bit positions
`define CNTR_INTEN 2  // Interrupt enable

`endif
